/* design/vga_consts.svh */
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// horizontal timing in pixels
`define VGA_H_ACTIVE 64
`define VGA_H_FRONT 4
`define VGA_H_SYNC 8
`define VGA_H_BACK 4
`define VGA_H_TOTAL (`VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)

// vertical timing in lines
`define VGA_V_ACTIVE 8
`define VGA_V_FRONT 1
`define VGA_V_SYNC 2
`define VGA_V_BACK 1
`define VGA_V_TOTAL (`VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)

`define VGA_PAL_ENTRIES 256

// byte addresses in system memory
`define VGA_PAL_BASE 32'hc001_3000
`define VGA_VID_BASE 32'hc000_0000

`endif

/* design/vga_pkg.sv */
`default_nettype none

package vga_pkg;

  // palette load first, then one row fetch per display line
  typedef enum logic [3:0] {
    PAL_REQ,
    PAL_NEXT,
    WAIT_LINE,
    LINE_REQ,
    MAP0,
    MAP1,
    MAP2,
    MAP3,
    LINE_NEXT
  } fetch_state_e;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

endpackage

`default_nettype wire

/* design/vga_if.sv */
`default_nettype none

`include "vga_consts.svh"

interface raster_if;
  localparam int XW = $clog2(`VGA_H_TOTAL);
  localparam int YW = $clog2(`VGA_V_TOTAL);

  logic          run;
  logic          pix_en;
  logic [XW-1:0] x;
  logic [YW-1:0] y;
  logic          active;
  logic          line_start;

  modport timing (input run, output pix_en, x, y, active, line_start);
  modport fetch (output run, input y, line_start);
  modport display (input pix_en, x, y);
endinterface

interface pal_if
  import vga_pkg::*;
();
  localparam int AW = $clog2(`VGA_PAL_ENTRIES);

  logic          wr_en;
  logic [AW-1:0] wr_addr;
  rgb_t          wr_data;
  logic [AW-1:0] rd_addr;
  rgb_t          rd_data;

  modport master (output wr_en, wr_addr, wr_data, rd_addr, input rd_data);
  modport ram (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);
endinterface

`default_nettype wire

/* design/vga_timing.sv */
`default_nettype none

`include "vga_consts.svh"

module vga_timing (
  input  wire       clk_i,
  input  wire       rst_i,
  raster_if.timing  raster,
  output logic      hs_o,
  output logic      vs_o,
  output logic      blank_n_o
);

  localparam int XW = $clog2(`VGA_H_TOTAL);
  localparam int YW = $clog2(`VGA_V_TOTAL);
  localparam int HS_START = `VGA_H_ACTIVE + `VGA_H_FRONT;
  localparam int VS_START = `VGA_V_ACTIVE + `VGA_V_FRONT;
  localparam int LINE_CLKS = 2 * `VGA_H_TOTAL;

  logic          pix_en_q;
  logic [XW-1:0] x_q;
  logic [YW-1:0] y_q;
  logic          in_hsync;
  logic          in_vsync;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pix_en_q <= 1'b0;
    end else begin
      pix_en_q <= ~pix_en_q;
    end
  end

  // counters wait in the last line of the frame until the palette is loaded
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      x_q <= '0;
      y_q <= YW'(`VGA_V_TOTAL - 1);
    end else if (raster.run && pix_en_q) begin
      if (x_q == XW'(`VGA_H_TOTAL - 1)) begin
        x_q <= '0;
        if (y_q == YW'(`VGA_V_TOTAL - 1)) begin
          y_q <= '0;
        end else begin
          y_q <= y_q + 1'b1;
        end
      end else begin
        x_q <= x_q + 1'b1;
      end
    end
  end

  assign in_hsync = (x_q >= XW'(HS_START)) && (x_q < XW'(HS_START + `VGA_H_SYNC));
  assign in_vsync = (y_q >= YW'(VS_START)) && (y_q < YW'(VS_START + `VGA_V_SYNC));

  assign raster.pix_en = pix_en_q;
  assign raster.x = x_q;
  assign raster.y = y_q;
  assign raster.active = (x_q < XW'(`VGA_H_ACTIVE)) && (y_q < YW'(`VGA_V_ACTIVE));
  assign raster.line_start = raster.run && pix_en_q && (x_q == '0);

  // registered like the line buffer read so sync, blank and colour line up
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      hs_o <= 1'b1;
      vs_o <= 1'b1;
      blank_n_o <= 1'b0;
    end else if (pix_en_q) begin
      hs_o <= ~in_hsync;
      vs_o <= ~in_vsync;
      blank_n_o <= raster.active;
    end
  end

  // once running, line starts come exactly one line period apart
  a_line_period: assert property (@(posedge clk_i) disable iff (rst_i)
    raster.line_start |=> !raster.line_start [*LINE_CLKS-1] ##1 raster.line_start);

endmodule

`default_nettype wire

/* design/palette_ram.sv */
`default_nettype none

`include "vga_consts.svh"

module palette_ram
  import vga_pkg::*;
(
  input wire    clk_i,
  pal_if.ram    pal
);

  rgb_t mem [`VGA_PAL_ENTRIES];

  always_ff @(posedge clk_i) begin
    if (pal.wr_en) begin
      mem[pal.wr_addr] <= pal.wr_data;
    end
  end

  // one clock of read latency
  always_ff @(posedge clk_i) begin
    pal.rd_data <= mem[pal.rd_addr];
  end

endmodule

`default_nettype wire

/* design/line_buffer.sv */
`default_nettype none

`include "vga_consts.svh"

module line_buffer
  import vga_pkg::*;
#(
  parameter int CW = $clog2(`VGA_H_ACTIVE)
) (
  input  wire              clk_i,
  input  wire              rst_i,
  raster_if.display        raster,
  input  wire              wr_en_i,
  input  wire              wr_bank_i,
  input  wire [CW-1:0]     wr_col_i,
  input  wire rgb_t        wr_rgb_i,
  output rgb_t             rgb_o
);

  localparam int YW = $clog2(`VGA_V_TOTAL);

  rgb_t mem [2][`VGA_H_ACTIVE];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_bank_i][wr_col_i] <= wr_rgb_i;
    end
  end

  // even rows live in bank 0 and odd rows in bank 1
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rgb_o <= '0;
    end else if (raster.pix_en) begin
      rgb_o <= mem[raster.y[0]][raster.x[CW-1:0]];
    end
  end

  // the fetch side must stay off the bank that is on screen
  a_bank_conflict: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_en_i && (raster.y < YW'(`VGA_V_ACTIVE)) |-> wr_bank_i != raster.y[0]);

endmodule

`default_nettype wire

/* design/fetch_engine.sv */
`default_nettype none

`include "vga_consts.svh"

module fetch_engine
  import vga_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  raster_if.fetch     raster,
  pal_if.master       pal,
  output logic [31:0] adr_o,
  output logic        cyc_o,
  output logic        stb_o,
  input  wire  [31:0] dat_i,
  input  wire         ack_i,
  output logic        wr_en_o,
  output logic        wr_bank_o,
  output logic [5:0]  wr_col_o,
  output rgb_t        wr_rgb_o
);

  localparam int AW = $clog2(`VGA_PAL_ENTRIES);
  localparam int YW = $clog2(`VGA_V_TOTAL);
  localparam int RW = $clog2(`VGA_V_ACTIVE);
  localparam int WW = $clog2(`VGA_H_ACTIVE / 4);

  fetch_state_e  state_q;
  logic [AW-1:0] idx_q;
  logic [RW-1:0] row_q;
  logic [WW-1:0] word_q;
  logic [31:0]   data_q;
  logic          run_q;
  logic          map_q;
  logic [5:0]    col_q;
  logic [YW-1:0] next_row;
  logic [1:0]    byte_sel;
  logic          is_map;

  // row shown on the line that follows the current one
  assign next_row = (raster.y == YW'(`VGA_V_TOTAL - 1)) ? '0 : raster.y + 1'b1;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= WAIT_LINE;
      idx_q <= '0;
      row_q <= '0;
      word_q <= '0;
      run_q <= 1'b0;
      map_q <= 1'b0;
    end else begin
      map_q <= is_map;
      case (state_q)
        WAIT_LINE: begin
          // coming out of reset the palette has not been read yet
          if (!run_q) begin
            state_q <= PAL_REQ;
          end else if (raster.line_start && (next_row < YW'(`VGA_V_ACTIVE))) begin
            row_q <= next_row[RW-1:0];
            word_q <= '0;
            state_q <= LINE_REQ;
          end
        end
        PAL_REQ: begin
          if (ack_i) begin
            state_q <= PAL_NEXT;
          end
        end
        PAL_NEXT: begin
          if (idx_q == AW'(`VGA_PAL_ENTRIES - 1)) begin
            run_q <= 1'b1;
            state_q <= WAIT_LINE;
          end else begin
            idx_q <= idx_q + 1'b1;
            state_q <= PAL_REQ;
          end
        end
        LINE_REQ: begin
          if (ack_i) begin
            state_q <= MAP0;
          end
        end
        MAP0: state_q <= MAP1;
        MAP1: state_q <= MAP2;
        MAP2: state_q <= MAP3;
        MAP3: state_q <= LINE_NEXT;
        LINE_NEXT: begin
          if (word_q == '1) begin
            state_q <= WAIT_LINE;
          end else begin
            word_q <= word_q + 1'b1;
            state_q <= LINE_REQ;
          end
        end
        default: state_q <= WAIT_LINE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == LINE_REQ) && ack_i) begin
      data_q <= dat_i;
    end
    col_q <= {word_q, byte_sel};
  end

  always_comb begin
    byte_sel = 2'd0;
    is_map = 1'b1;
    case (state_q)
      MAP0: byte_sel = 2'd0;
      MAP1: byte_sel = 2'd1;
      MAP2: byte_sel = 2'd2;
      MAP3: byte_sel = 2'd3;
      default: is_map = 1'b0;
    endcase
  end

  // highest byte of the word is the leftmost pixel
  assign pal.rd_addr = data_q[8 * (3 - byte_sel) +: 8];

  assign pal.wr_en = (state_q == PAL_REQ) && ack_i;
  assign pal.wr_addr = idx_q;
  assign pal.wr_data = rgb_t'(dat_i[23:0]);

  assign cyc_o = (state_q == PAL_REQ) || (state_q == LINE_REQ);
  assign stb_o = cyc_o;
  assign adr_o = (state_q == PAL_REQ) ? `VGA_PAL_BASE + 32'({idx_q, 2'b00})
                                      : `VGA_VID_BASE + 32'({row_q, word_q, 2'b00});

  assign raster.run = run_q;

  // palette data arrives a clock after the index, so the write follows it
  assign wr_en_o = map_q;
  assign wr_bank_o = row_q[0];
  assign wr_col_o = col_q;
  assign wr_rgb_o = pal.rd_data;

  a_adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_o && !ack_i |=> stb_o && $stable(adr_o));

  // a row fetch has to finish inside one line period
  a_fetch_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    raster.line_start |-> state_q == WAIT_LINE);

endmodule

`default_nettype wire

/* design/vga_master.sv */
`default_nettype none

module vga_master
  import vga_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  output logic [31:0] adr_o,
  output logic        cyc_o,
  output logic        stb_o,
  input  wire  [31:0] dat_i,
  input  wire         ack_i,
  output logic        hs_o,
  output logic        vs_o,
  output logic        blank_n_o,
  output logic [7:0]  r_o,
  output logic [7:0]  g_o,
  output logic [7:0]  b_o
);

  raster_if raster ();
  pal_if    pal ();

  logic       wr_en;
  logic       wr_bank;
  logic [5:0] wr_col;
  rgb_t       wr_rgb;
  rgb_t       pixel;

  vga_timing timing_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raster    (raster.timing),
    .hs_o      (hs_o),
    .vs_o      (vs_o),
    .blank_n_o (blank_n_o)
  );

  palette_ram palette_inst (
    .clk_i (clk_i),
    .pal   (pal.ram)
  );

  line_buffer line_buffer_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raster    (raster.display),
    .wr_en_i   (wr_en),
    .wr_bank_i (wr_bank),
    .wr_col_i  (wr_col),
    .wr_rgb_i  (wr_rgb),
    .rgb_o     (pixel)
  );

  fetch_engine fetch_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raster    (raster.fetch),
    .pal       (pal.master),
    .adr_o     (adr_o),
    .cyc_o     (cyc_o),
    .stb_o     (stb_o),
    .dat_i     (dat_i),
    .ack_i     (ack_i),
    .wr_en_o   (wr_en),
    .wr_bank_o (wr_bank),
    .wr_col_o  (wr_col),
    .wr_rgb_o  (wr_rgb)
  );

  assign r_o = pixel.r;
  assign g_o = pixel.g;
  assign b_o = pixel.b;

endmodule

`default_nettype wire

/* dv/vga_master_tb.sv */
`default_nettype none

`include "vga_consts.svh"

module vga_master_tb;

  localparam int PERIOD = 40;
  localparam int FRAMES = 3;
  localparam int LINE_CLKS = 2 * `VGA_H_TOTAL;
  localparam int ACT_CLKS = 2 * `VGA_H_ACTIVE;
  localparam int HS_CLKS = 2 * `VGA_H_SYNC;
  localparam int ROW_WORDS = `VGA_H_ACTIVE / 4;
  localparam int VID_WORDS = `VGA_V_ACTIVE * ROW_WORDS;
  localparam int RUN_CLKS = `VGA_PAL_ENTRIES * 6 + (FRAMES + 1) * `VGA_V_TOTAL * LINE_CLKS;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] dat_i;
  logic        ack_i;
  logic [31:0] adr_o;
  logic        cyc_o;
  logic        stb_o;
  logic        hs_o;
  logic        vs_o;
  logic        blank_n_o;
  logic [7:0]  r_o;
  logic [7:0]  g_o;
  logic [7:0]  b_o;

  logic [31:0] pal_mem [`VGA_PAL_ENTRIES];
  logic [31:0] vid_mem [VID_WORDS];
  logic [31:0] rng;
  logic [1:0]  waits;
  logic [23:0] exp_rgb;
  logic        blank_q;
  logic        hs_q;
  logic        vs_q;
  logic        period_valid;
  int          bus_errors;
  int          pixel_errors;
  int          timing_errors;
  int          rd_cnt;
  int          rows_fetched;
  int          lines_shown;
  int          frame_lines;
  int          frames_done;
  int          pixel_checks;
  int          act_clks;
  int          hs_clks;
  int          vs_clks;
  int          line_clks;

  vga_master vga_master_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .adr_o     (adr_o),
    .cyc_o     (cyc_o),
    .stb_o     (stb_o),
    .dat_i     (dat_i),
    .ack_i     (ack_i),
    .hs_o      (hs_o),
    .vs_o      (vs_o),
    .blank_n_o (blank_n_o),
    .r_o       (r_o),
    .g_o       (g_o),
    .b_o       (b_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // palette reads first, then rows 0 to 7 over and over
  function automatic logic [31:0] expected_adr(input int n);
    int m;
    if (n < `VGA_PAL_ENTRIES) begin
      return `VGA_PAL_BASE + 32'(4 * n);
    end
    m = n - `VGA_PAL_ENTRIES;
    return `VGA_VID_BASE + 32'(4 * ROW_WORDS * ((m / ROW_WORDS) % `VGA_V_ACTIVE)
                              + 4 * (m % ROW_WORDS));
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] adr);
    logic [31:0] off;
    off = adr - `VGA_PAL_BASE;
    if (off < 32'(4 * `VGA_PAL_ENTRIES)) begin
      return pal_mem[off[9:2]];
    end
    off = adr - `VGA_VID_BASE;
    if (off < 32'(4 * VID_WORDS)) begin
      return vid_mem[off[8:2]];
    end
    return 32'h0;
  endfunction

  // leftmost pixel of a word sits in its top byte
  function automatic logic [23:0] expected_rgb(input int row, input int col);
    logic [31:0] word;
    logic [7:0]  idx;
    word = vid_mem[7'(row * ROW_WORDS + col / 4)];
    idx = word[8 * (3 - col % 4) +: 8];
    return pal_mem[idx][23:0];
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(2 * PERIOD * RUN_CLKS);
    $display("timeout: the run did not reach %0d frames in time", FRAMES);
    $display("Something failed");
    $finish;
  end

  // bus slave that acks each read after 0 to 3 wait states
  initial begin
    @(negedge rst_i);
    forever begin
      @(posedge clk_i);
      #1;
      if (ack_i) begin
        ack_i = 1'b0;
      end else if (cyc_o) begin
        if (waits == 2'd0) begin
          assert (adr_o == expected_adr(rd_cnt)) else begin
            bus_errors++;
            $display("mismatch at %0t: read %0d at %h, expected %h",
                     $time, rd_cnt, adr_o, expected_adr(rd_cnt));
          end
          if (rd_cnt >= `VGA_PAL_ENTRIES &&
              (rd_cnt - `VGA_PAL_ENTRIES) % ROW_WORDS == ROW_WORDS - 1) begin
            rows_fetched++;
          end
          rd_cnt++;
          dat_i = read_word(adr_o);
          ack_i = 1'b1;
          rng = xorshift(rng);
          waits = rng[1:0];
        end else begin
          waits = waits - 2'd1;
        end
      end
    end
  end

  a_stb_is_cyc: assert property (@(posedge clk_i) stb_o == cyc_o) else begin
    bus_errors++;
    $display("mismatch at %0t: stb_o %b differs from cyc_o %b", $time, stb_o, cyc_o);
  end

  a_idle_in_reset: assert property (@(posedge clk_i) rst_i |-> !cyc_o) else begin
    bus_errors++;
    $display("mismatch at %0t: cyc_o high during reset", $time);
  end

  a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_o && !ack_i |=> cyc_o && $stable(adr_o)) else begin
    bus_errors++;
    $display("mismatch at %0t: request dropped or moved to %h before ack", $time, adr_o);
  end

  // outputs move after rising edges, so the video checks run on falling edges
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (blank_n_o) begin
        if (!blank_q) begin
          assert (rows_fetched == lines_shown + 1) else begin
            timing_errors++;
            $display("mismatch at %0t: %0d rows fetched at start of line %0d",
                     $time, rows_fetched, lines_shown);
          end
        end
        exp_rgb = expected_rgb(lines_shown % `VGA_V_ACTIVE, act_clks / 2);
        assert ({r_o, g_o, b_o} == exp_rgb) else begin
          pixel_errors++;
          $display("mismatch at %0t: row %0d col %0d rgb %h, expected %h", $time,
                   lines_shown % `VGA_V_ACTIVE, act_clks / 2, {r_o, g_o, b_o}, exp_rgb);
        end
        pixel_checks++;
        act_clks++;
      end else if (blank_q) begin
        assert (act_clks == ACT_CLKS) else begin
          timing_errors++;
          $display("mismatch at %0t: %0d active clocks in a line", $time, act_clks);
        end
        act_clks = 0;
        lines_shown++;
        frame_lines++;
      end
      if (!hs_o) begin
        hs_clks++;
      end else if (!hs_q) begin
        assert (hs_clks == HS_CLKS) else begin
          timing_errors++;
          $display("mismatch at %0t: hs_o low for %0d clocks", $time, hs_clks);
        end
        hs_clks = 0;
      end
      if (!hs_o && hs_q) begin
        if (period_valid) begin
          assert (line_clks == LINE_CLKS) else begin
            timing_errors++;
            $display("mismatch at %0t: line period of %0d clocks", $time, line_clks);
          end
        end
        period_valid = 1'b1;
        line_clks = 0;
      end
      line_clks++;
      if (!vs_o) begin
        vs_clks++;
      end else if (!vs_q) begin
        assert (vs_clks == `VGA_V_SYNC * LINE_CLKS) else begin
          timing_errors++;
          $display("mismatch at %0t: vs_o low for %0d clocks", $time, vs_clks);
        end
        vs_clks = 0;
        frames_done++;
      end
      if (!vs_o && vs_q) begin
        assert (frame_lines == `VGA_V_ACTIVE) else begin
          timing_errors++;
          $display("mismatch at %0t: %0d active lines in a frame", $time, frame_lines);
        end
        frame_lines = 0;
      end
      blank_q = blank_n_o;
      hs_q = hs_o;
      vs_q = vs_o;
    end
  end

  initial begin
    rst_i = 1'b1;
    dat_i = 32'h0;
    ack_i = 1'b0;
    waits = 2'd0;
    blank_q = 1'b0;
    hs_q = 1'b1;
    vs_q = 1'b1;
    period_valid = 1'b0;
    rng = 32'd44499;
    for (int i = 0; i < `VGA_PAL_ENTRIES; i++) begin
      rng = xorshift(rng);
      pal_mem[i] = rng;
    end
    for (int i = 0; i < VID_WORDS; i++) begin
      rng = xorshift(rng);
      vid_mem[i] = rng;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    wait (frames_done == FRAMES);
    @(negedge clk_i);
    if (pixel_checks != FRAMES * `VGA_V_ACTIVE * ACT_CLKS) begin
      timing_errors++;
      $display("only %0d pixel clocks were checked", pixel_checks);
    end
    $display("errors: bus %0d, pixel %0d, timing %0d", bus_errors, pixel_errors,
             timing_errors);
    if (bus_errors + pixel_errors + timing_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/vga_pkg.sv
design/vga_if.sv
design/vga_timing.sv
design/palette_ram.sv
design/line_buffer.sv
design/fetch_engine.sv
design/vga_master.sv
dv/vga_master_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = vga_master_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
